// File: Makefile
VERILATOR ?= verilator
TOP ?= fetch_tb
FILE_LIST ?= fetch_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell cat $(FILE_LIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/fetch_pkg.sv
package fetch_pkg;

	// Architectural register number, x0 to x31
	typedef logic [4:0] reg_index_t;

	// Wrapping count of fetched instructions
	typedef logic [7:0] fetch_tag_t;

	typedef logic [6:0] opcode_t;

	// One predecoded instruction handed from fetch to decode
	typedef struct packed {
		fetch_tag_t tag;
		logic [31:0] pc;
		logic [31:0] instruction;
		reg_index_t rs1;
		reg_index_t rs2;
		reg_index_t rd;
	} fetch_entry_t;

	// RV32I major opcodes, instruction bits 6:0
	localparam opcode_t OPCODE_OP = 7'b0110011;
	localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
	localparam opcode_t OPCODE_LOAD = 7'b0000011;
	localparam opcode_t OPCODE_STORE = 7'b0100011;
	localparam opcode_t OPCODE_BRANCH = 7'b1100011;
	localparam opcode_t OPCODE_JAL = 7'b1101111;
	localparam opcode_t OPCODE_JALR = 7'b1100111;
	localparam opcode_t OPCODE_LUI = 7'b0110111;
	localparam opcode_t OPCODE_AUIPC = 7'b0010111;

	// ECALL, MRET and WFI have funct3 zero, CSR accesses do not
	localparam opcode_t OPCODE_SYSTEM = 7'b1110011;

endpackage

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
	input logic i_clock,
	input logic i_reset,

	input logic i_jump,
	input logic [31:0] i_jump_pc,

	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	output logic [31:0] o_icache_pc,
	output logic o_icache_stall,
	input logic [31:0] i_icache_rdata,
	input logic i_icache_ready,

	input logic i_queue_full,
	output logic o_push,
	output fetch_entry_t o_push_entry
);

	typedef enum logic [0:0] {
		WAIT_ICACHE,
		WAIT_JUMP
	} fetch_state_t;

	fetch_state_t state;
	logic [31:0] pc;
	fetch_tag_t tag_count;

	reg_index_t rs1;
	reg_index_t rs2;
	reg_index_t rd;
	logic control_transfer;
	logic fetch_accept;

	predecoder predecoder0 (
		.i_instruction(i_icache_rdata),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_rd(rd),
		.o_control_transfer(control_transfer)
	);

	assign o_icache_pc = pc;

	// No refills while parked on a branch or with nowhere to put the word
	assign o_icache_stall = state == WAIT_JUMP || i_queue_full;

	assign fetch_accept = state == WAIT_ICACHE && i_icache_ready && !i_queue_full;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= WAIT_ICACHE;
			pc <= RESET_VECTOR;
			tag_count <= '0;
			o_push <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end else begin
			o_push <= 1'b0;
			o_irq_dispatched <= 1'b0;
			// Interrupt wins over both fetch and jump
			if (i_irq_pending) begin
				pc <= i_irq_pc;
				state <= WAIT_ICACHE;
				o_irq_dispatched <= 1'b1;
			end else begin
				case (state)
					WAIT_ICACHE: begin
						if (fetch_accept) begin
							o_push <= 1'b1;
							tag_count <= tag_count + 8'd1;
							if (control_transfer) begin
								state <= WAIT_JUMP;
							end else begin
								pc <= pc + 32'd4;
							end
						end
					end
					WAIT_JUMP: begin
						// Decode resolves the target and sends it back
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= WAIT_ICACHE;
						end
					end
					default: state <= WAIT_ICACHE;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (fetch_accept && !i_irq_pending) begin
			o_push_entry.tag <= tag_count + 8'd1;
			o_push_entry.pc <= pc;
			o_push_entry.instruction <= i_icache_rdata;
			o_push_entry.rs1 <= rs1;
			o_push_entry.rs2 <= rs2;
			o_push_entry.rd <= rd;
		end
		if (i_irq_pending) begin
			o_irq_epc <= pc;
		end
	end

	// Interrupt source drops its request once dispatch is seen
	irq_single_pulse_a: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched);

endmodule

// File: fetch/predecoder.sv
`timescale 1ns/1ps

module predecoder import fetch_pkg::*; (
	input logic [31:0] i_instruction,
	output reg_index_t o_rs1,
	output reg_index_t o_rs2,
	output reg_index_t o_rd,
	output logic o_control_transfer
);

	opcode_t opcode;
	logic [2:0] funct3;

	logic is_r;
	logic is_i;
	logic is_s;
	logic is_b;
	logic is_u;
	logic is_j;
	logic is_csr;
	logic is_system_call;

	logic have_rs1;
	logic have_rs2;
	logic have_rd;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];

	// Instruction format by opcode
	assign is_r = opcode == OPCODE_OP;
	assign is_i = opcode == OPCODE_OP_IMM || opcode == OPCODE_LOAD || opcode == OPCODE_JALR;
	assign is_s = opcode == OPCODE_STORE;
	assign is_b = opcode == OPCODE_BRANCH;
	assign is_u = opcode == OPCODE_LUI || opcode == OPCODE_AUIPC;
	assign is_j = opcode == OPCODE_JAL;
	assign is_csr = opcode == OPCODE_SYSTEM && funct3 != 3'b000;

	// ECALL, MRET, WFI
	assign is_system_call = opcode == OPCODE_SYSTEM && funct3 == 3'b000;

	assign have_rs1 = is_r || is_i || is_s || is_b || is_csr;
	assign have_rs2 = is_r || is_s || is_b;
	assign have_rd = is_r || is_i || is_u || is_j || is_csr;

	// Unused index fields read as x0
	assign o_rs1 = have_rs1 ? i_instruction[19:15] : '0;
	assign o_rs2 = have_rs2 ? i_instruction[24:20] : '0;
	assign o_rd = have_rd ? i_instruction[11:7] : '0;

	// Anything after which the next PC is not known at fetch time
	assign o_control_transfer = opcode == OPCODE_JAL
		|| opcode == OPCODE_JALR
		|| is_b
		|| is_system_call;

endmodule

// File: fetch_top.f
common/fetch_pkg.sv
fetch/predecoder.sv
fetch/fetch_unit.sv
icache/icache.sv
logic/fetch_queue.sv
logic/fetch_top.sv
verification/fetch_tb_memory.sv
verification/fetch_tb.sv

// File: icache/icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int ICACHE_LINES = 16
) (
	input logic i_clock,
	input logic i_reset,

	input logic [31:0] i_pc,
	input logic i_stall,
	output logic [31:0] o_rdata,
	output logic o_ready,

	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	// One word per line
	logic [ICACHE_LINES-1:0] line_valid;
	logic [TAG_BITS-1:0] line_tag [ICACHE_LINES];
	logic [31:0] line_data [ICACHE_LINES];

	logic [INDEX_BITS-1:0] lookup_index;
	logic [TAG_BITS-1:0] lookup_tag;

	logic refill_active;
	logic [31:0] refill_address;
	logic [INDEX_BITS-1:0] refill_index;
	logic [TAG_BITS-1:0] refill_tag;
	logic refill_start;
	logic refill_done;

	assign lookup_index = i_pc[INDEX_BITS+1:2];
	assign lookup_tag = i_pc[31:INDEX_BITS+2];

	// Hit path is purely combinational
	assign o_ready = line_valid[lookup_index] && line_tag[lookup_index] == lookup_tag;
	assign o_rdata = line_data[lookup_index];

	assign refill_index = refill_address[INDEX_BITS+1:2];
	assign refill_tag = refill_address[31:INDEX_BITS+2];

	// A running refill always completes, stall only blocks the next one
	assign refill_start = !refill_active && !o_ready && !i_stall;
	assign refill_done = refill_active && i_bus_ready;

	assign o_bus_request = refill_active;
	assign o_bus_address = refill_address;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			refill_active <= 1'b0;
			line_valid <= '0;
		end else if (refill_done) begin
			refill_active <= 1'b0;
			line_valid[refill_index] <= 1'b1;
		end else if (refill_start) begin
			refill_active <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (refill_start) begin
			refill_address <= {i_pc[31:2], 2'b00};
		end
		// Line usable from the following cycle
		if (refill_done) begin
			line_tag[refill_index] <= refill_tag;
			line_data[refill_index] <= i_bus_rdata;
		end
	end

	// Request held with a fixed address until memory answers
	bus_request_hold_a: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address));

endmodule

// File: logic/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_push,
	input fetch_entry_t i_push_entry,
	output logic o_full,

	input logic i_decode_busy,
	output logic o_valid,
	output fetch_entry_t o_entry
);

	// Slot 0 is always the head
	fetch_entry_t slot [2];
	logic [1:0] count;
	logic pop;
	logic push_slot;

	assign o_valid = count != 2'd0;
	assign o_entry = slot[0];
	assign pop = o_valid && !i_decode_busy;

	// The pusher decides a cycle ahead, so a push in flight takes the last slot
	assign o_full = count == 2'd2 || (count == 2'd1 && i_push);

	// Lands behind whatever is left after this cycle's pop
	assign push_slot = count == 2'd2 || (count == 2'd1 && !pop);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= 2'd0;
		end else if (i_push && !pop) begin
			count <= count + 2'd1;
		end else if (pop && !i_push) begin
			count <= count - 2'd1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (pop) begin
			slot[0] <= slot[1];
		end
		// Overrides the shift when the queue drains to the new entry
		if (i_push) begin
			slot[push_slot] <= i_push_entry;
		end
	end

	// The fetch unit must respect the full flag
	push_not_full_a: assert property (@(posedge i_clock) disable iff (i_reset)
		i_push |-> count != 2'd2);

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
	parameter int ICACHE_LINES = 16
) (
	input logic i_clock,
	input logic i_reset,

	input logic i_jump,
	input logic [31:0] i_jump_pc,

	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata,

	input logic i_decode_busy,
	output logic o_valid,
	output fetch_entry_t o_entry
);

	logic [31:0] icache_pc;
	logic icache_stall;
	logic [31:0] icache_rdata;
	logic icache_ready;

	logic queue_full;
	logic push;
	fetch_entry_t push_entry;

	icache #(
		.ICACHE_LINES(ICACHE_LINES)
	) icache0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(icache_pc),
		.i_stall(icache_stall),
		.o_rdata(icache_rdata),
		.o_ready(icache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	fetch_unit #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch_unit0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_icache_pc(icache_pc),
		.o_icache_stall(icache_stall),
		.i_icache_rdata(icache_rdata),
		.i_icache_ready(icache_ready),
		.i_queue_full(queue_full),
		.o_push(push),
		.o_push_entry(push_entry)
	);

	fetch_queue fetch_queue0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_push(push),
		.i_push_entry(push_entry),
		.o_full(queue_full),
		.i_decode_busy(i_decode_busy),
		.o_valid(o_valid),
		.o_entry(o_entry)
	);

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*;;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
	localparam int TIMEOUT = 400;

	logic i_clock = 1'b0;
	logic i_reset = 1'b1;
	logic i_jump = 1'b0;
	logic [31:0] i_jump_pc = '0;
	logic i_irq_pending = 1'b0;
	logic [31:0] i_irq_pc = '0;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic bus_request;
	logic [31:0] bus_address;
	logic bus_ready;
	logic [31:0] bus_rdata;
	logic i_decode_busy = 1'b0;
	logic o_valid;
	fetch_entry_t o_entry;

	int error_count = 0;
	int timeout_count = 0;
	logic [31:0] lfsr_state = 32'hf8125a03;
	int stretch_left = 0;

	// Scoreboard state
	logic [31:0] exp_pc;
	logic [7:0] exp_tag;
	logic [31:0] last_ctl_pc;
	logic waiting_jump;
	logic second_pass = 1'b0;
	logic saw_dispatch = 1'b0;
	int transfer_count;
	logic transfer;
	logic [31:0] exp_instr;
	logic [14:0] exp_fields;

	fetch_top #(
		.RESET_VECTOR(RESET_VECTOR),
		.ICACHE_LINES(16)
	) dut0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(bus_request),
		.o_bus_address(bus_address),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.i_decode_busy(i_decode_busy),
		.o_valid(o_valid),
		.o_entry(o_entry)
	);

	fetch_tb_memory mem0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

	function automatic logic is_control(input logic [31:0] instr);
		return instr[6:0] == OPCODE_JAL || instr[6:0] == OPCODE_JALR
			|| instr[6:0] == OPCODE_BRANCH
			|| (instr[6:0] == OPCODE_SYSTEM && instr[14:12] == 3'b000);
	endfunction

	// Expected {rs1, rs2, rd} by instruction format
	function automatic logic [14:0] select_fields(input logic [31:0] instr);
		logic [6:0] op;
		logic csr;
		logic r1;
		logic r2;
		logic wr;
		op = instr[6:0];
		csr = op == OPCODE_SYSTEM && instr[14:12] != 3'b000;
		r1 = op inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR,
			OPCODE_STORE, OPCODE_BRANCH} || csr;
		r2 = op inside {OPCODE_OP, OPCODE_STORE, OPCODE_BRANCH};
		wr = op inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR,
			OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL} || csr;
		return {r1 ? instr[19:15] : 5'd0, r2 ? instr[24:20] : 5'd0, wr ? instr[11:7] : 5'd0};
	endfunction

	function automatic logic [3:0] take_bits(input int count);
		logic [3:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[2:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
		end
		return value;
	endfunction

	initial begin
		forever #4 i_clock = ~i_clock;
	end

	assign transfer = o_valid && !i_decode_busy;
	assign exp_instr = mem0.word_at(exp_pc);
	assign exp_fields = select_fields(exp_instr);

	always @(posedge i_clock) begin
		if (i_reset) begin
			exp_pc <= RESET_VECTOR;
			exp_tag <= 8'd1;
			waiting_jump <= 1'b0;
			transfer_count <= 0;
		end else begin
			if (transfer) begin
				exp_tag <= exp_tag + 8'd1;
				transfer_count <= transfer_count + 1;
				if (is_control(exp_instr)) begin
					waiting_jump <= 1'b1;
					last_ctl_pc <= exp_pc;
				end else begin
					exp_pc <= exp_pc + 32'd4;
				end
			end
			if (i_irq_pending) begin
				exp_pc <= i_irq_pc;
				waiting_jump <= 1'b0;
			end else if (i_jump && waiting_jump) begin
				exp_pc <= i_jump_pc;
				waiting_jump <= 1'b0;
			end
			if (o_irq_dispatched) begin
				saw_dispatch <= 1'b1;
			end
		end
	end

	// Decode busy in random stretches of 1 to 4 cycles
	always @(negedge i_clock) begin
		if (!i_reset) begin
			if (stretch_left == 0) begin
				i_decode_busy = take_bits(1) == 4'd1;
				stretch_left = take_bits(2) + 1;
			end
			stretch_left = stretch_left - 1;
		end
	end

	pc_a: assert property (@(posedge i_clock) disable iff (i_reset)
		transfer |-> o_entry.pc == exp_pc)
		else begin
			error_count++;
			$display("ERR pc expected %h actual %h", $sampled(exp_pc), $sampled(o_entry.pc));
		end
	tag_a: assert property (@(posedge i_clock) disable iff (i_reset)
		transfer |-> o_entry.tag == exp_tag)
		else begin
			error_count++;
			$display("ERR tag expected %h actual %h", $sampled(exp_tag), $sampled(o_entry.tag));
		end
	instr_a: assert property (@(posedge i_clock) disable iff (i_reset)
		transfer |-> o_entry.instruction == exp_instr)
		else begin
			error_count++;
			$display("ERR instruction expected %h actual %h", $sampled(exp_instr),
				$sampled(o_entry.instruction));
		end
	predecode_a: assert property (@(posedge i_clock) disable iff (i_reset)
		transfer |-> {o_entry.rs1, o_entry.rs2, o_entry.rd} == exp_fields)
		else begin
			error_count++;
			$display("ERR predecode expected %h actual %h", $sampled(exp_fields),
				$sampled({o_entry.rs1, o_entry.rs2, o_entry.rd}));
		end
	parked_a: assert property (@(posedge i_clock) disable iff (i_reset) waiting_jump |-> !o_valid)
		else begin
			error_count++;
			$display("Entry appeared while fetch waited for a jump target");
		end
	hit_a: assert property (@(posedge i_clock) disable iff (i_reset) second_pass |-> !bus_request)
		else begin
			error_count++;
			$display("Bus request seen while the loop should hit in the cache");
		end
	bus_hold_a: assert property (@(posedge i_clock) disable iff (i_reset)
		bus_request && !bus_ready |=> bus_request && $stable(bus_address))
		else begin
			error_count++;
			$display("Bus request dropped or its address changed before ready");
		end
	bus_release_a: assert property (@(posedge i_clock) disable iff (i_reset)
		bus_request && bus_ready |=> !bus_request)
		else begin
			error_count++;
			$display("Bus request still high after the ready cycle");
		end
	epc_a: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |-> o_irq_epc == last_ctl_pc)
		else begin
			error_count++;
			$display("ERR irq_epc expected %h actual %h", $sampled(last_ctl_pc),
				$sampled(o_irq_epc));
		end
	irq_pulse_a: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched)
		else begin
			error_count++;
			$display("Interrupt dispatch stayed high for more than one cycle");
		end

	task automatic wait_parked(input string what);
		int cycles;
		cycles = 0;
		while (!waiting_jump && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (!waiting_jump) begin
			timeout_count++;
			$display("Timed out waiting for a control transfer (%s)", what);
		end
	endtask

	task automatic wait_transfers(input int target);
		int cycles;
		cycles = 0;
		while (transfer_count < target && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (transfer_count < target) begin
			timeout_count++;
			$display("Timed out waiting for %0d transferred entries", target);
		end
	endtask

	task automatic wait_dispatch();
		int cycles;
		cycles = 0;
		while (!saw_dispatch && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (!saw_dispatch) begin
			timeout_count++;
			$display("Timed out waiting for the interrupt dispatch");
		end
	endtask

	task automatic strobe_jump(input logic [31:0] target);
		@(negedge i_clock);
		i_jump = 1'b1;
		i_jump_pc = target;
		@(negedge i_clock);
		i_jump = 1'b0;
	endtask

	initial begin
		repeat (4) @(negedge i_clock);
		i_reset <= 1'b0;
		// First pass fills the cache up to the branch
		wait_parked("first pass");
		second_pass = 1'b1;
		strobe_jump(RESET_VECTOR);
		wait_transfers(16);
		wait_parked("second pass");
		second_pass = 1'b0;
		@(negedge i_clock);
		i_irq_pending = 1'b1;
		i_irq_pc = 32'h120;
		@(negedge i_clock);
		i_irq_pending = 1'b0;
		wait_dispatch();
		wait_parked("jal");
		strobe_jump(32'h124);
		wait_parked("ecall");
		strobe_jump(32'h200);
		wait_transfers(30);
		repeat (4) @(negedge i_clock);
		$display("errors: %0d check, %0d timeout", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verification/fetch_tb_memory.sv
`timescale 1ns/1ps

module fetch_tb_memory import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input logic [31:0] i_bus_address,
	output logic o_bus_ready,
	output logic [31:0] o_bus_rdata
);

	logic [31:0] lfsr_state = 32'hf8125a03;
	int delay_left = 0;
	logic ready = 1'b0;
	logic [31:0] rdata = '0;

	assign o_bus_ready = ready;
	assign o_bus_rdata = rdata;

	// Program image at 0x100, outside of it a pattern that folds in every address bit
	function automatic logic [31:0] word_at(input logic [31:0] address);
		logic [11:0] fold;
		fold = address[31:20] ^ address[19:8] ^ {4'd0, address[7:0]};
		case (address)
			32'h100: return {12'd5, 5'd2, 3'b000, 5'd1, OPCODE_OP_IMM};
			32'h104: return {7'd0, 5'd5, 5'd4, 3'b000, 5'd3, OPCODE_OP};
			32'h108: return {7'd0, 5'd6, 5'd7, 3'b010, 5'd8, OPCODE_STORE};
			32'h10c: return {20'h12345, 5'd8, OPCODE_LUI};
			32'h110: return {12'd4, 5'd10, 3'b010, 5'd9, OPCODE_LOAD};
			32'h114: return {20'h00001, 5'd11, OPCODE_AUIPC};
			32'h118: return {12'h300, 5'd13, 3'b001, 5'd12, OPCODE_SYSTEM};
			32'h11c: return {7'b1111111, 5'd15, 5'd14, 3'b000, 5'b00101, OPCODE_BRANCH};
			32'h120: return {20'h00100, 5'd1, OPCODE_JAL};
			32'h124: return {25'd0, OPCODE_SYSTEM};
			32'h128: return {12'd0, 5'd1, 3'b000, 5'd0, OPCODE_JALR};
			default: return {fold, address[6:2], 3'b000, address[11:7], OPCODE_OP_IMM};
		endcase
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? (state >> 1) ^ 32'h80200003 : state >> 1;
	endfunction

	// Ready answers after 1 to 4 cycles
	always @(negedge i_clock) begin
		if (i_reset) begin
			ready = 1'b0;
			delay_left = 0;
		end else if (ready) begin
			ready = 1'b0;
		end else if (i_bus_request) begin
			if (delay_left == 0) begin
				delay_left = 1 + lfsr_state[0];
				lfsr_state = lfsr_step(lfsr_state);
				delay_left = delay_left + 2 * lfsr_state[0];
				lfsr_state = lfsr_step(lfsr_state);
			end
			delay_left = delay_left - 1;
			if (delay_left == 0) begin
				ready = 1'b1;
				rdata = word_at(i_bus_address);
			end
		end
	end

endmodule
